// File: list.f
common/petModePkg.sv
common/petNeedPkg.sv
hw/decode/cmdDecoder.sv
hw/execute/moodFsm.sv
hw/execute/needTimers.sv
hw/result/faceEncoder.sv
hw/petTop.sv
tb/petTb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module petTb -f list.f -o petSim
	@out="$$(./obj_dir/petSim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

// File: tb/petTb.sv
`timescale 1ns/1ns

module petTb import petModePkg::*, petNeedPkg::*; ();

	// sum of the test lengths is well under this
	localparam int TIMEOUT_CYCLES = 3000;
	localparam int BTN_SLEEP = 0;
	localparam int BTN_WAKE = 1;
	localparam int BTN_FEED = 2;
	localparam int BTN_PLAY = 3;
	localparam int BTN_TEST = 4;
	// cycles per level step in the DUT
	localparam int ENERGY_PERIOD = 40;
	localparam int HUNGER_PERIOD = 20;
	localparam int FUN_PERIOD = 30;

	logic clk = 1'b0;
	logic rst;
	logic [4:0] btns;
	logic [3:0] testPreset;
	petMood face;
	logic [4:0] energyBar;
	logic [4:0] hungerBar;
	logic [4:0] funBar;
	logic alarm;
	needLevels levels;
	int errorCount = 0;
	int checkCount = 0;
	int cycleCount = 0;

	// preset table, indexed by preset number
	int tableE [1:9] = '{5, 4, 2, 2, 5, 2, 5, 5, 0};
	int tableH [1:9] = '{5, 4, 5, 5, 2, 2, 5, 5, 0};
	int tableF [1:9] = '{5, 4, 5, 5, 5, 5, 2, 2, 0};
	petMood tableMood [1:9] = '{IDLE, NEUTRAL, TIRED, SLEEP, HUNGRY, SAD, PLAYING, BORED, DEATH};

	petTop #(
		.energyPeriod(ENERGY_PERIOD),
		.hungerPeriod(HUNGER_PERIOD),
		.funPeriod(FUN_PERIOD)
	) uut (
		.clk(clk),
		.rst(rst),
		.sleepBtn(btns[BTN_SLEEP]),
		.wakeBtn(btns[BTN_WAKE]),
		.feedBtn(btns[BTN_FEED]),
		.playBtn(btns[BTN_PLAY]),
		.testBtn(btns[BTN_TEST]),
		.testPreset(testPreset),
		.face(face),
		.energyBar(energyBar),
		.hungerBar(hungerBar),
		.funBar(funBar),
		.alarm(alarm),
		.levels(levels)
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Simulation failed");
			$finish;
		end
	end

	// bar bit k lit while the level is above k
	function automatic logic [4:0] thermo(int lvl);
		logic [4:0] bar;
		for (int k = 0; k < 5; k++) begin
			bar[k] = (lvl > k);
		end
		return bar;
	endfunction

	// mood of an awake pet for the given levels
	function automatic petMood ruleFace(int e, int h, int f);
		int lows;
		lows = int'(e <= 2) + int'(h <= 2) + int'(f <= 2);
		if (e == 0 || h == 0 || f == 0) return DEATH;
		if (lows >= 2) return SAD;
		if (e <= 2) return TIRED;
		if (h <= 2) return HUNGRY;
		if (f <= 2) return BORED;
		if (e == 5 && h == 5 && f == 5) return IDLE;
		return NEUTRAL;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("FAILED at %0t ns: %s is %0d, expected %0d", $time, name, actual, expected);
		end
	endtask

	// face, levels, bars and alarm against one expected state
	task automatic checkState(input petMood m, input int e, input int h, input int f);
		checkValue("face", face, m);
		checkValue("energy", levels.energy, e);
		checkValue("hunger", levels.hunger, h);
		checkValue("fun", levels.fun, f);
		checkValue("energyBar", energyBar, thermo(e));
		checkValue("hungerBar", hungerBar, thermo(h));
		checkValue("funBar", funBar, thermo(f));
		checkValue("alarm", alarm, ((e <= 2) || (h <= 2) || (f <= 2)) && (m != DEATH));
	endtask

	task automatic resetDut();
		rst = 1'b1;
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;
	endtask

	// hold for two cycles, then leave time for the command to reach the face
	task automatic pressBtn(input int idx);
		btns[idx] = 1'b1;
		repeat (2) @(posedge clk);
		#1;
		btns[idx] = 1'b0;
		repeat (8) @(posedge clk);
		#1;
	endtask

	task automatic applyPreset(input int p);
		testPreset = 4'(p);
		pressBtn(BTN_TEST);
	endtask

	task automatic waitFaceLeave(input petMood m, input int limit);
		int n;
		n = 0;
		while (face == m && n < limit) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (face == m) begin
			errorCount++;
			$display("face never left %s within %0d cycles", m.name(), limit);
		end
	endtask

	task automatic checkAfterReset();
		checkState(IDLE, 5, 5, 5);
	endtask

	task automatic presetSweep();
		for (int p = 1; p <= 9; p++) begin
			applyPreset(p);
			checkState(tableMood[p], tableE[p], tableH[p], tableF[p]);
			if (p == 3) begin
				checkValue("hunger at or below 5", levels.hunger <= 5, 1);
				checkValue("fun at or below 5", levels.fun <= 5, 1);
				checkValue("alarm after preset 3", alarm, 1);
			end
		end
		// a dead pet only comes back through reset
		resetDut();
		checkState(IDLE, 5, 5, 5);
	endtask

	task automatic feedHunger();
		applyPreset(5);
		pressBtn(BTN_FEED);
		checkState(ruleFace(5, 3, 5), 5, 3, 5);
		applyPreset(2);
		pressBtn(BTN_FEED);
		checkState(ruleFace(4, 5, 4), 4, 5, 4);
	endtask

	task automatic sleepCycle();
		applyPreset(4);
		checkState(SLEEP, 2, 5, 5);
		// energy refills in three steps, hunger and fun hold meanwhile
		waitFaceLeave(SLEEP, 200);
		checkState(IDLE, 5, 5, 5);
		// energy below full so the pet stays asleep until woken
		applyPreset(2);
		pressBtn(BTN_SLEEP);
		checkState(SLEEP, 4, 4, 4);
		pressBtn(BTN_WAKE);
		checkState(ruleFace(4, 4, 4), 4, 4, 4);
	endtask

	task automatic playCycle();
		int playLen;
		int e;
		int h;
		int f;
		// fun climbs from 2 to full while energy and hunger keep decaying
		playLen = (5 - 2) * FUN_PERIOD;
		e = 5 - playLen / ENERGY_PERIOD;
		h = 5 - playLen / HUNGER_PERIOD;
		f = 5;
		applyPreset(7);
		checkState(PLAYING, 5, 5, 2);
		waitFaceLeave(PLAYING, 200);
		checkState(ruleFace(e, h, f), e, h, f);
		// second play press ends the game early
		applyPreset(8);
		pressBtn(BTN_PLAY);
		checkState(PLAYING, 5, 5, 2);
		pressBtn(BTN_PLAY);
		checkState(ruleFace(5, 5, 2), 5, 5, 2);
	endtask

	task automatic deathAndRecover();
		applyPreset(9);
		checkState(DEATH, 0, 0, 0);
		pressBtn(BTN_FEED);
		applyPreset(1);
		pressBtn(BTN_WAKE);
		repeat (100) @(posedge clk);
		#1;
		checkState(DEATH, 0, 0, 0);
		resetDut();
		checkState(IDLE, 5, 5, 5);
	endtask

	initial begin
		rst = 1'b1;
		btns = '0;
		testPreset = '0;
		resetDut();
		checkAfterReset();
		presetSweep();
		feedHunger();
		sleepCycle();
		playCycle();
		deathAndRecover();
		$display("%0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: hw/petTop.sv
`timescale 1ns/1ns

module petTop import petModePkg::*, petNeedPkg::*; #(
	// cycles per level step, defaults give 30 s, 10 s and 20 s at 50 MHz
	parameter int energyPeriod = 1500000000,
	parameter int hungerPeriod = 500000000,
	parameter int funPeriod = 1000000000
) (
	input logic clk,
	input logic rst,
	input logic sleepBtn,
	input logic wakeBtn,
	input logic feedBtn,
	input logic playBtn,
	input logic testBtn,
	input logic [3:0] testPreset,
	output petMood face,
	output logic [4:0] energyBar,
	output logic [4:0] hungerBar,
	output logic [4:0] funBar,
	output logic alarm,
	output needLevels levels
);

	logic cmdValid;
	logic cmdReady;
	petCmd cmd;
	petMood mood;
	needCtrl ctrl;

	cmdDecoder decode (
		.clk(clk),
		.rst(rst),
		.sleepBtn(sleepBtn),
		.wakeBtn(wakeBtn),
		.feedBtn(feedBtn),
		.playBtn(playBtn),
		.testBtn(testBtn),
		.testPreset(testPreset),
		.cmdReady(cmdReady),
		.cmdValid(cmdValid),
		.cmd(cmd)
	);

	moodFsm fsm (
		.clk(clk),
		.rst(rst),
		.cmdValid(cmdValid),
		.cmd(cmd),
		.cmdReady(cmdReady),
		.levels(levels),
		.mood(mood),
		.ctrl(ctrl)
	);

	needTimers #(
		.energyPeriod(energyPeriod),
		.hungerPeriod(hungerPeriod),
		.funPeriod(funPeriod)
	) needs (
		.clk(clk),
		.rst(rst),
		.ctrl(ctrl),
		.levels(levels)
	);

	faceEncoder result (
		.clk(clk),
		.rst(rst),
		.mood(mood),
		.levels(levels),
		.face(face),
		.energyBar(energyBar),
		.hungerBar(hungerBar),
		.funBar(funBar),
		.alarm(alarm)
	);

endmodule

// File: hw/result/faceEncoder.sv
`timescale 1ns/1ns

module faceEncoder import petModePkg::*, petNeedPkg::*; (
	input logic clk,
	input logic rst,
	input petMood mood,
	input needLevels levels,
	output petMood face,
	output logic [4:0] energyBar,
	output logic [4:0] hungerBar,
	output logic [4:0] funBar,
	output logic alarm
);

	logic lowNeed;

	// thermometer code, bit k lit while the level is above k
	function automatic logic [4:0] toBar(needLevel lvl);
		logic [4:0] bar;
		for (int k = 0; k < 5; k++) begin
			bar[k] = (lvl > 3'(k));
		end
		return bar;
	endfunction

	assign lowNeed = (levels.energy <= 3'd2) || (levels.hunger <= 3'd2) || (levels.fun <= 3'd2);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			face <= IDLE;
			energyBar <= 5'b11111;
			hungerBar <= 5'b11111;
			funBar <= 5'b11111;
			alarm <= 1'b0;
		end else begin
			face <= mood;
			energyBar <= toBar(levels.energy);
			hungerBar <= toBar(levels.hunger);
			funBar <= toBar(levels.fun);
			// no point alarming once the pet is dead
			alarm <= lowNeed && (mood != DEATH);
		end
	end

endmodule

// File: hw/execute/needTimers.sv
`timescale 1ns/1ns

module needTimers import petNeedPkg::*; #(
	parameter int energyPeriod = 1500000000,
	parameter int hungerPeriod = 500000000,
	parameter int funPeriod = 1000000000
) (
	input logic clk,
	input logic rst,
	input needCtrl ctrl,
	output needLevels levels
);

	localparam int MAX_PERIOD = (energyPeriod > hungerPeriod) ?
		((energyPeriod > funPeriod) ? energyPeriod : funPeriod) :
		((hungerPeriod > funPeriod) ? hungerPeriod : funPeriod);
	localparam int CNT_W = $clog2(MAX_PERIOD + 1);

	// index 0 energy, 1 hunger, 2 fun
	needLevel lvl [3];
	needLevel loadArr [3];
	needLevels loadVal;
	logic [2:0] runMask;
	logic [2:0] upMask;
	logic [2:0] feedMask;
	logic actChange;
	petActivity prevAct;

	function automatic needLevels presetLevels(logic [3:0] sel, needLevels cur);
		case (sel)
			4'd1: return '{energy: 3'd5, hunger: 3'd5, fun: 3'd5};
			4'd2: return '{energy: 3'd4, hunger: 3'd4, fun: 3'd4};
			4'd3: return '{energy: 3'd2, hunger: 3'd5, fun: 3'd5};
			4'd4: return '{energy: 3'd2, hunger: 3'd5, fun: 3'd5};
			4'd5: return '{energy: 3'd5, hunger: 3'd2, fun: 3'd5};
			4'd6: return '{energy: 3'd2, hunger: 3'd2, fun: 3'd5};
			4'd7: return '{energy: 3'd5, hunger: 3'd5, fun: 3'd2};
			4'd8: return '{energy: 3'd5, hunger: 3'd5, fun: 3'd2};
			4'd9: return '{energy: 3'd0, hunger: 3'd0, fun: 3'd0};
			default: return cur;
		endcase
	endfunction

	assign loadVal = presetLevels(ctrl.preset, levels);
	assign loadArr[0] = loadVal.energy;
	assign loadArr[1] = loadVal.hunger;
	assign loadArr[2] = loadVal.fun;
	assign feedMask = {1'b0, ctrl.feed, 1'b0};

	// which needs run their timer, and in which direction
	always_comb begin
		case (ctrl.activity)
			ACT_AWAKE: begin
				runMask = 3'b111;
				upMask = 3'b000;
			end
			ACT_SLEEP: begin
				runMask = 3'b001;
				upMask = 3'b001;
			end
			ACT_PLAY: begin
				runMask = 3'b111;
				upMask = 3'b100;
			end
			default: begin
				runMask = 3'b000;
				upMask = 3'b000;
			end
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			prevAct <= ACT_AWAKE;
		end else begin
			prevAct <= ctrl.activity;
		end
	end

	assign actChange = (ctrl.activity != prevAct);

	for (genvar i = 0; i < 3; i++) begin : gNeed
		localparam int PERIOD = (i == 0) ? energyPeriod : (i == 1) ? hungerPeriod : funPeriod;

		needLevel lvlQ;
		logic [CNT_W-1:0] cntQ;
		logic stepNow;

		assign stepNow = runMask[i] && !actChange && (cntQ == CNT_W'(PERIOD - 1));

		always_ff @(posedge clk or posedge rst) begin
			if (rst) begin
				lvlQ <= NEED_MAX;
				cntQ <= '0;
			end else if (ctrl.load) begin
				lvlQ <= loadArr[i];
				cntQ <= '0;
			end else begin
				if (actChange || stepNow) begin
					cntQ <= '0;
				end else if (runMask[i]) begin
					cntQ <= cntQ + 1'b1;
				end
				// feed wins over a timed step in the same cycle
				if (feedMask[i]) begin
					lvlQ <= (lvlQ < NEED_MAX) ? lvlQ + 3'd1 : lvlQ;
				end else if (stepNow && upMask[i]) begin
					lvlQ <= (lvlQ < NEED_MAX) ? lvlQ + 3'd1 : lvlQ;
				end else if (stepNow) begin
					lvlQ <= (lvlQ != 3'd0) ? lvlQ - 3'd1 : lvlQ;
				end
			end
		end

		assign lvl[i] = lvlQ;
	end

	assign levels = '{energy: lvl[0], hunger: lvl[1], fun: lvl[2]};

endmodule

// File: hw/execute/moodFsm.sv
`timescale 1ns/1ns

module moodFsm import petModePkg::*, petNeedPkg::*; (
	input logic clk,
	input logic rst,
	input logic cmdValid,
	input petCmd cmd,
	output logic cmdReady,
	input needLevels levels,
	output petMood mood,
	output needCtrl ctrl
);

	petMood moodNext;
	petActivity activity;
	logic accept;
	logic presetValid;
	logic isLoad;
	logic anyZero;

	// mood an awake pet shows for the given levels
	function automatic petMood ruleMood(needLevels lv);
		logic lowE;
		logic lowH;
		logic lowF;
		logic [1:0] lowCount;
		lowE = (lv.energy <= 3'd2);
		lowH = (lv.hunger <= 3'd2);
		lowF = (lv.fun <= 3'd2);
		lowCount = {1'b0, lowE} + {1'b0, lowH} + {1'b0, lowF};
		if (lv.energy == 3'd0 || lv.hunger == 3'd0 || lv.fun == 3'd0) begin
			return DEATH;
		end else if (lowCount >= 2'd2) begin
			return SAD;
		end else if (lowE) begin
			return TIRED;
		end else if (lowH) begin
			return HUNGRY;
		end else if (lowF) begin
			return BORED;
		end else if (lv.energy == NEED_MAX && lv.hunger == NEED_MAX && lv.fun == NEED_MAX) begin
			return IDLE;
		end
		return NEUTRAL;
	endfunction

	// mood forced by a test preset, levels come from needTimers
	function automatic petMood presetMood(logic [3:0] sel, petMood cur);
		case (sel)
			4'd1: return IDLE;
			4'd2: return NEUTRAL;
			4'd3: return TIRED;
			4'd4: return SLEEP;
			4'd5: return HUNGRY;
			4'd6: return SAD;
			4'd7: return PLAYING;
			4'd8: return BORED;
			4'd9: return DEATH;
			default: return cur;
		endcase
	endfunction

	// a dead pet takes one command and then stalls decode until reset
	assign cmdReady = (mood != DEATH);
	assign accept = cmdValid && cmdReady;
	assign presetValid = (cmd.preset >= PRESET_FIRST) && (cmd.preset <= PRESET_LAST);
	assign isLoad = accept && (cmd.op == CMD_TEST) && presetValid;
	assign anyZero = (levels.energy == 3'd0) || (levels.hunger == 3'd0) || (levels.fun == 3'd0);

	always_comb begin
		moodNext = mood;
		if (mood != DEATH) begin
			if (isLoad) begin
				moodNext = presetMood(cmd.preset, mood);
			end else if (anyZero) begin
				moodNext = DEATH;
			end else begin
				case (mood)
					SLEEP: begin
						if ((accept && cmd.op == CMD_WAKE) || levels.energy == NEED_MAX) begin
							moodNext = ruleMood(levels);
						end
					end
					PLAYING: begin
						// second play press or full fun ends the game
						if ((accept && cmd.op == CMD_PLAY) || levels.fun == NEED_MAX) begin
							moodNext = ruleMood(levels);
						end
					end
					default: begin
						if (accept && cmd.op == CMD_SLEEP) begin
							moodNext = SLEEP;
						end else if (accept && cmd.op == CMD_PLAY) begin
							moodNext = PLAYING;
						end else begin
							moodNext = ruleMood(levels);
						end
					end
				endcase
			end
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			mood <= IDLE;
		end else begin
			mood <= moodNext;
		end
	end

	always_comb begin
		case (mood)
			SLEEP: activity = ACT_SLEEP;
			PLAYING: activity = ACT_PLAY;
			DEATH: activity = ACT_FROZEN;
			default: activity = ACT_AWAKE;
		endcase
	end

	// feed and load leave here combinationally so levels move with the mood
	assign ctrl = '{
		activity: activity,
		feed: accept && (cmd.op == CMD_FEED),
		load: isLoad,
		preset: cmd.preset
	};

endmodule

// File: hw/decode/cmdDecoder.sv
`timescale 1ns/1ns

module cmdDecoder import petModePkg::*; (
	input logic clk,
	input logic rst,
	input logic sleepBtn,
	input logic wakeBtn,
	input logic feedBtn,
	input logic playBtn,
	input logic testBtn,
	input logic [3:0] testPreset,
	input logic cmdReady,
	output logic cmdValid,
	output petCmd cmd
);

	// bit order is {test, sleep, wake, feed, play}, highest priority first
	logic [4:0] btnMeta;
	logic [4:0] btnSync;
	logic [4:0] btnPrev;
	logic [4:0] press;
	logic pressAny;
	logic [3:0] presetMeta;
	logic [3:0] presetSync;
	petCmdOp pressOp;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			btnMeta <= '0;
			btnSync <= '0;
			btnPrev <= '0;
		end else begin
			btnMeta <= {testBtn, sleepBtn, wakeBtn, feedBtn, playBtn};
			btnSync <= btnMeta;
			btnPrev <= btnSync;
		end
	end

	// preset switch only matters once a test press is latched
	always_ff @(posedge clk) begin
		presetMeta <= testPreset;
		presetSync <= presetMeta;
	end

	assign press = btnSync & ~btnPrev;
	assign pressAny = |press;

	always_comb begin
		if (press[4]) begin
			pressOp = CMD_TEST;
		end else if (press[3]) begin
			pressOp = CMD_SLEEP;
		end else if (press[2]) begin
			pressOp = CMD_WAKE;
		end else if (press[1]) begin
			pressOp = CMD_FEED;
		end else begin
			pressOp = CMD_PLAY;
		end
	end

	// presses arriving while a command waits are dropped
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cmdValid <= 1'b0;
		end else if (cmdValid) begin
			if (cmdReady) begin
				cmdValid <= 1'b0;
			end
		end else if (pressAny) begin
			cmdValid <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!cmdValid && pressAny) begin
			cmd <= '{op: pressOp, preset: presetSync};
		end
	end

endmodule

// File: common/petNeedPkg.sv
package petNeedPkg;

	// need level, 0 is empty and 5 is full
	typedef logic [2:0] needLevel;

	localparam needLevel NEED_MAX = 3'd5;

	typedef struct packed {
		needLevel energy;
		needLevel hunger;
		needLevel fun;
	} needLevels;

	// what the pet is doing, selects decay or recovery per need
	typedef enum logic [1:0] {
		ACT_AWAKE,
		ACT_SLEEP,
		ACT_PLAY,
		ACT_FROZEN
	} petActivity;

	typedef struct packed {
		petActivity activity;
		logic feed;
		logic load;
		logic [3:0] preset;
	} needCtrl;

endpackage

// File: common/petModePkg.sv
package petModePkg;

	// pet moods, also used directly as the face code
	typedef enum logic [3:0] {
		IDLE,
		NEUTRAL,
		TIRED,
		HUNGRY,
		BORED,
		SAD,
		SLEEP,
		PLAYING,
		DEATH
	} petMood;

	// one command per accepted button press
	typedef enum logic [2:0] {
		CMD_SLEEP,
		CMD_WAKE,
		CMD_FEED,
		CMD_PLAY,
		CMD_TEST
	} petCmdOp;

	// command word from decode to execute
	typedef struct packed {
		petCmdOp op;
		// preset index, only looked at for CMD_TEST
		logic [3:0] preset;
	} petCmd;

	// valid preset numbers on the switch
	localparam logic [3:0] PRESET_FIRST = 4'd1;
	localparam logic [3:0] PRESET_LAST = 4'd9;

endpackage
